//--- hw/umstr_cfg_pkg.sv
package umstr_cfg_pkg;

    // bus side widths
    typedef logic [6:0]  axil_addr_t;
    typedef logic [4:0]  word_idx_t;
    typedef logic [31:0] data_t;
    typedef logic [3:0]  strb_t;

    // network fields
    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] port_t;

    // per-field table strobes, bit 0 mac, bit 1 ip, bit 2 port
    typedef logic [2:0]  cell_wr_t;

    // word map, byte address is word index times four
    localparam word_idx_t WORD_CONTROL     = 5'd0;
    localparam word_idx_t WORD_MAC_SRC_HI  = 5'd1;
    localparam word_idx_t WORD_MAC_SRC_LO  = 5'd2;
    localparam word_idx_t WORD_IP_SRC      = 5'd3;
    localparam word_idx_t WORD_PORT_SRC    = 5'd4;
    localparam word_idx_t WORD_CELL_ADDR   = 5'd5;
    localparam word_idx_t WORD_MAC_DEST_HI = 5'd6;
    localparam word_idx_t WORD_MAC_DEST_LO = 5'd7;
    localparam word_idx_t WORD_IP_DEST     = 5'd8;
    localparam word_idx_t WORD_PORT_DEST   = 5'd9;
    localparam word_idx_t WORD_CELL_WRITE  = 5'd10;
    localparam word_idx_t WORD_SERIAL      = 5'd11;
    localparam word_idx_t WORD_WRAND       = 5'd12;
    localparam word_idx_t WORD_WBURST      = 5'd13;
    localparam word_idx_t WORD_RRAND       = 5'd14;
    localparam word_idx_t WORD_RBURST      = 5'd15;

    // board identity after reset
    localparam mac_t  MAC_SRC_DEFAULT  = 48'h012345678901;
    localparam ip_t   IP_SRC_DEFAULT   = 32'h12345678;
    localparam port_t PORT_SRC_DEFAULT = 16'h1234;

    // id and transaction code defaults
    localparam data_t SERIAL_DEFAULT = 32'h12345678;
    localparam data_t WRAND_DEFAULT  = 32'h12345678;
    localparam data_t WBURST_DEFAULT = 32'h12345678;
    localparam data_t RRAND_DEFAULT  = 32'h12345678;
    localparam data_t RBURST_DEFAULT = 32'h12345678;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // half-width words live on lanes 0 and 1
    localparam strb_t HALF_LANES = 4'b0011;

    // replace each strobed byte of the old word
    function automatic data_t merge_lanes(data_t old_word, data_t new_data, strb_t strb);
        data_t result;
        result = old_word;
        for (int lane = 0; lane < $bits(strb_t); lane++) begin
            if (strb[lane]) begin
                result[8*lane +: 8] = new_data[8*lane +: 8];
            end
        end
        return result;
    endfunction

    // same merge for a 16 bit field, upper lanes ignored
    function automatic port_t merge_half(port_t old_half, data_t new_data, strb_t strb);
        return port_t'(merge_lanes(data_t'(old_half), new_data, strb & HALF_LANES));
    endfunction

endpackage

//--- hw/axil_write_slave.sv
`timescale 1ns/1ps

module axil_write_slave (
    input  logic                      clk_i,
    input  logic                      reset_n_i,

    // write address channel
    input  umstr_cfg_pkg::axil_addr_t awaddr_i,
    input  logic                      awvalid_i,
    output logic                      awready_o,

    // write data channel
    input  umstr_cfg_pkg::data_t      wdata_i,
    input  umstr_cfg_pkg::strb_t      wstrb_i,
    input  logic                      wvalid_i,
    output logic                      wready_o,

    // write response channel
    output logic [1:0]                bresp_o,
    output logic                      bvalid_o,
    input  logic                      bready_i,

    // register side
    output logic                      wr_stb_o,
    output umstr_cfg_pkg::word_idx_t  wr_word_o,
    output umstr_cfg_pkg::data_t      wr_data_o,
    output umstr_cfg_pkg::strb_t      wr_strb_o
);
    import umstr_cfg_pkg::*;

    // holding flags, one per channel
    logic       aw_held;
    logic       w_held;
    // held payload
    axil_addr_t aw_addr_q;
    data_t      w_data_q;
    strb_t      w_strb_q;
    // response and strobe state
    logic       bvalid_q;
    logic       wr_stb_q;
    // handshakes
    logic       aw_hs;
    logic       w_hs;
    logic       b_hs;
    logic       fire;

    // each channel accepts once, and nothing while a response waits
    assign awready_o = !aw_held && !bvalid_q;
    assign wready_o  = !w_held && !bvalid_q;

    assign aw_hs = awvalid_i && awready_o;
    assign w_hs  = wvalid_i && wready_o;
    assign b_hs  = bvalid_q && bready_i;

    // both halves present and no response out yet
    assign fire = aw_held && w_held && !bvalid_q;

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else if (b_hs) begin
            // transaction done, free both channels
            aw_held <= 1'b0;
            w_held  <= 1'b0;
        end else begin
            if (aw_hs) begin
                aw_held <= 1'b1;
            end
            if (w_hs) begin
                w_held <= 1'b1;
            end
        end
    end

    // payload capture
    always_ff @(posedge clk_i) begin
        if (aw_hs) begin
            aw_addr_q <= awaddr_i;
        end
        if (w_hs) begin
            w_data_q <= wdata_i;
            w_strb_q <= wstrb_i;
        end
    end

    // strobe and bvalid rise together on the same edge
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            wr_stb_q <= 1'b0;
            bvalid_q <= 1'b0;
        end else begin
            wr_stb_q <= fire;
            if (b_hs) begin
                bvalid_q <= 1'b0;
            end else if (fire) begin
                bvalid_q <= 1'b1;
            end
        end
    end

    assign bvalid_o  = bvalid_q;
    assign bresp_o   = RESP_OKAY;
    assign wr_stb_o  = wr_stb_q;
    // drop the byte offset
    assign wr_word_o = aw_addr_q[6:2];
    assign wr_data_o = w_data_q;
    assign wr_strb_o = w_strb_q;

    // response must wait for the master
    a_bvalid_hold: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        bvalid_q && !bready_i |=> bvalid_q
    ) else $error("bvalid dropped before bready");

    // one strobe per transaction
    a_wr_stb_single: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        wr_stb_q |=> !wr_stb_q
    ) else $error("wr_stb high for two cycles");

endmodule

//--- hw/src_param_regs.sv
`timescale 1ns/1ps

module src_param_regs (
    input  logic                     clk_i,
    input  logic                     reset_n_i,

    // write port from the slave
    input  logic                     wr_stb_i,
    input  umstr_cfg_pkg::word_idx_t wr_word_i,
    input  umstr_cfg_pkg::data_t     wr_data_i,
    input  umstr_cfg_pkg::strb_t     wr_strb_i,

    // board identity and control
    output umstr_cfg_pkg::data_t     control_o,
    output umstr_cfg_pkg::mac_t      mac_src_o,
    output umstr_cfg_pkg::ip_t       ip_src_o,
    output umstr_cfg_pkg::port_t     port_src_o
);
    import umstr_cfg_pkg::*;

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            control_o  <= '0;
            mac_src_o  <= MAC_SRC_DEFAULT;
            ip_src_o   <= IP_SRC_DEFAULT;
            port_src_o <= PORT_SRC_DEFAULT;
        end else if (wr_stb_i) begin
            case (wr_word_i)
                WORD_CONTROL: begin
                    control_o <= merge_lanes(control_o, wr_data_i, wr_strb_i);
                end
                // mac high half on lanes 0 and 1
                WORD_MAC_SRC_HI: begin
                    mac_src_o[47:32] <= merge_half(mac_src_o[47:32], wr_data_i, wr_strb_i);
                end
                WORD_MAC_SRC_LO: begin
                    mac_src_o[31:0] <= merge_lanes(mac_src_o[31:0], wr_data_i, wr_strb_i);
                end
                WORD_IP_SRC: begin
                    ip_src_o <= merge_lanes(ip_src_o, wr_data_i, wr_strb_i);
                end
                WORD_PORT_SRC: begin
                    port_src_o <= merge_half(port_src_o, wr_data_i, wr_strb_i);
                end
                // other words belong elsewhere
                default: begin
                end
            endcase
        end
    end

    // identity must be defined at every edge out of reset
    a_src_known: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        !$isunknown({control_o, mac_src_o, ip_src_o, port_src_o})
    ) else $error("source parameter register unknown");

endmodule

//--- hw/dest_cell_stage.sv
`timescale 1ns/1ps

module dest_cell_stage (
    input  logic                     clk_i,
    input  logic                     reset_n_i,

    // write port from the slave
    input  logic                     wr_stb_i,
    input  umstr_cfg_pkg::word_idx_t wr_word_i,
    input  umstr_cfg_pkg::data_t     wr_data_i,
    input  umstr_cfg_pkg::strb_t     wr_strb_i,

    // staged destination for the selected channel cell
    output umstr_cfg_pkg::data_t     cell_addr_o,
    output umstr_cfg_pkg::mac_t      mac_dest_o,
    output umstr_cfg_pkg::ip_t       ip_dest_o,
    output umstr_cfg_pkg::port_t     port_dest_o,
    output umstr_cfg_pkg::cell_wr_t  cell_wr_o
);
    import umstr_cfg_pkg::*;

    // pulse request, lane 0 carries the field mask
    logic cell_wr_hit;

    assign cell_wr_hit = wr_stb_i && (wr_word_i == WORD_CELL_WRITE) && wr_strb_i[0];

    // staging area, only meaningful once software has filled it
    always_ff @(posedge clk_i) begin
        if (wr_stb_i) begin
            case (wr_word_i)
                WORD_CELL_ADDR: begin
                    cell_addr_o <= merge_lanes(cell_addr_o, wr_data_i, wr_strb_i);
                end
                WORD_MAC_DEST_HI: begin
                    mac_dest_o[47:32] <= merge_half(mac_dest_o[47:32], wr_data_i, wr_strb_i);
                end
                WORD_MAC_DEST_LO: begin
                    mac_dest_o[31:0] <= merge_lanes(mac_dest_o[31:0], wr_data_i, wr_strb_i);
                end
                WORD_IP_DEST: begin
                    ip_dest_o <= merge_lanes(ip_dest_o, wr_data_i, wr_strb_i);
                end
                WORD_PORT_DEST: begin
                    port_dest_o <= merge_half(port_dest_o, wr_data_i, wr_strb_i);
                end
                default: begin
                end
            endcase
        end
    end

    // one cycle strobes toward the destination table
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            cell_wr_o <= '0;
        end else if (cell_wr_hit) begin
            cell_wr_o <= wr_data_i[2:0];
        end else begin
            cell_wr_o <= '0;
        end
    end

    // table must never store an unwritten field
    a_cell_addr_known: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        (cell_wr_o != '0) |-> !$isunknown(cell_addr_o)
    ) else $error("cell address unknown at cell write");

    a_mac_dest_known: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        cell_wr_o[0] |-> !$isunknown(mac_dest_o)
    ) else $error("destination mac unknown at cell write");

    a_ip_dest_known: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        cell_wr_o[1] |-> !$isunknown(ip_dest_o)
    ) else $error("destination ip unknown at cell write");

    a_port_dest_known: assert property (
        @(posedge clk_i) disable iff (!reset_n_i)
        cell_wr_o[2] |-> !$isunknown(port_dest_o)
    ) else $error("destination port unknown at cell write");

endmodule

//--- hw/id_code_regs.sv
`timescale 1ns/1ps

module id_code_regs #(
    // serial number fixed in hardware
    parameter bit lock_serial = 1'b1,
    // all four transaction codes fixed in hardware
    parameter bit lock_codes  = 1'b0
) (
    input  logic                     clk_i,
    input  logic                     reset_n_i,

    // write port from the slave
    input  logic                     wr_stb_i,
    input  umstr_cfg_pkg::word_idx_t wr_word_i,
    input  umstr_cfg_pkg::data_t     wr_data_i,
    input  umstr_cfg_pkg::strb_t     wr_strb_i,

    // core id and transaction codes
    output umstr_cfg_pkg::data_t     serial_o,
    output umstr_cfg_pkg::data_t     wrand_code_o,
    output umstr_cfg_pkg::data_t     wburst_code_o,
    output umstr_cfg_pkg::data_t     rrand_code_o,
    output umstr_cfg_pkg::data_t     rburst_code_o
);
    import umstr_cfg_pkg::*;

    // field 0 is the serial, 1 to 4 the codes in map order
    data_t fields [5];

    for (genvar i = 0; i < 5; i++) begin : g_field
        // words 11 to 15 are contiguous
        localparam word_idx_t FIELD_WORD = word_idx_t'(WORD_SERIAL + i);
        localparam data_t FIELD_DEFAULT = (i == 0) ? SERIAL_DEFAULT :
                                          (i == 1) ? WRAND_DEFAULT  :
                                          (i == 2) ? WBURST_DEFAULT :
                                          (i == 3) ? RRAND_DEFAULT  :
                                                     RBURST_DEFAULT;
        localparam bit FIELD_LOCKED = (i == 0) ? lock_serial : lock_codes;

        data_t field_q;

        if (FIELD_LOCKED) begin : g_locked
            // writes are acknowledged and ignored
            assign field_q = FIELD_DEFAULT;
        end else begin : g_open
            always_ff @(posedge clk_i or negedge reset_n_i) begin
                if (!reset_n_i) begin
                    field_q <= FIELD_DEFAULT;
                end else if (wr_stb_i && (wr_word_i == FIELD_WORD)) begin
                    field_q <= merge_lanes(field_q, wr_data_i, wr_strb_i);
                end
            end
        end

        assign fields[i] = field_q;
    end

    assign serial_o      = fields[0];
    assign wrand_code_o  = fields[1];
    assign wburst_code_o = fields[2];
    assign rrand_code_o  = fields[3];
    assign rburst_code_o = fields[4];

endmodule

//--- hw/umstr_cfg_regs.sv
`timescale 1ns/1ps

module umstr_cfg_regs #(
    parameter bit lock_serial = 1'b1,
    parameter bit lock_codes  = 1'b0
) (
    input  logic                      clk_i,
    input  logic                      reset_n_i,

    // axi-lite write slave
    input  umstr_cfg_pkg::axil_addr_t awaddr_i,
    input  logic                      awvalid_i,
    output logic                      awready_o,
    input  umstr_cfg_pkg::data_t      wdata_i,
    input  umstr_cfg_pkg::strb_t      wstrb_i,
    input  logic                      wvalid_i,
    output logic                      wready_o,
    output logic [1:0]                bresp_o,
    output logic                      bvalid_o,
    input  logic                      bready_i,

    // source side
    output umstr_cfg_pkg::data_t      control_o,
    output umstr_cfg_pkg::mac_t       mac_src_o,
    output umstr_cfg_pkg::ip_t        ip_src_o,
    output umstr_cfg_pkg::port_t      port_src_o,

    // destination staging
    output umstr_cfg_pkg::data_t      cell_addr_o,
    output umstr_cfg_pkg::mac_t       mac_dest_o,
    output umstr_cfg_pkg::ip_t        ip_dest_o,
    output umstr_cfg_pkg::port_t      port_dest_o,
    output umstr_cfg_pkg::cell_wr_t   cell_wr_o,

    // id block
    output umstr_cfg_pkg::data_t      serial_o,
    output umstr_cfg_pkg::data_t      wrand_code_o,
    output umstr_cfg_pkg::data_t      wburst_code_o,
    output umstr_cfg_pkg::data_t      rrand_code_o,
    output umstr_cfg_pkg::data_t      rburst_code_o
);
    import umstr_cfg_pkg::*;

    // register write bus shared by all groups
    logic      wr_stb;
    word_idx_t wr_word;
    data_t     wr_data;
    strb_t     wr_strb;

    axil_write_slave u_slave (
        .clk_i     (clk_i),
        .reset_n_i (reset_n_i),
        .awaddr_i  (awaddr_i),
        .awvalid_i (awvalid_i),
        .awready_o (awready_o),
        .wdata_i   (wdata_i),
        .wstrb_i   (wstrb_i),
        .wvalid_i  (wvalid_i),
        .wready_o  (wready_o),
        .bresp_o   (bresp_o),
        .bvalid_o  (bvalid_o),
        .bready_i  (bready_i),
        .wr_stb_o  (wr_stb),
        .wr_word_o (wr_word),
        .wr_data_o (wr_data),
        .wr_strb_o (wr_strb)
    );

    src_param_regs u_src (
        .clk_i      (clk_i),
        .reset_n_i  (reset_n_i),
        .wr_stb_i   (wr_stb),
        .wr_word_i  (wr_word),
        .wr_data_i  (wr_data),
        .wr_strb_i  (wr_strb),
        .control_o  (control_o),
        .mac_src_o  (mac_src_o),
        .ip_src_o   (ip_src_o),
        .port_src_o (port_src_o)
    );

    dest_cell_stage u_dest (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .wr_stb_i    (wr_stb),
        .wr_word_i   (wr_word),
        .wr_data_i   (wr_data),
        .wr_strb_i   (wr_strb),
        .cell_addr_o (cell_addr_o),
        .mac_dest_o  (mac_dest_o),
        .ip_dest_o   (ip_dest_o),
        .port_dest_o (port_dest_o),
        .cell_wr_o   (cell_wr_o)
    );

    id_code_regs #(
        .lock_serial (lock_serial),
        .lock_codes  (lock_codes)
    ) u_id (
        .clk_i         (clk_i),
        .reset_n_i     (reset_n_i),
        .wr_stb_i      (wr_stb),
        .wr_word_i     (wr_word),
        .wr_data_i     (wr_data),
        .wr_strb_i     (wr_strb),
        .serial_o      (serial_o),
        .wrand_code_o  (wrand_code_o),
        .wburst_code_o (wburst_code_o),
        .rrand_code_o  (rrand_code_o),
        .rburst_code_o (rburst_code_o)
    );

endmodule

//--- include/tb_axil_tasks.svh
// one write with the address leading the data by aw_first cycles
// a negative aw_first lets the data lead, zero offers both together
task automatic axil_write(input axil_addr_t addr, input data_t data, input strb_t strb,
                          input int aw_first, input int bready_delay);
    int lead;
    int cycles;
    bit aw_pend;
    bit w_pend;
    bit aw_hs;
    bit w_hs;
    bit b_seen;
    bit b_done;
    lead    = (aw_first < 0) ? -aw_first : aw_first;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    cycles  = 0;
    awvalid = aw_first >= 0;
    wvalid  = aw_first <= 0;
    // address and data phase, readys sampled mid cycle
    while (aw_pend || w_pend) begin
        #1;
        aw_hs = awvalid && awready;
        w_hs  = wvalid && wready;
        next_cycle();
        cycles++;
        if (aw_hs) begin
            aw_pend = 1'b0;
        end
        if (w_hs) begin
            w_pend = 1'b0;
        end
        awvalid = aw_pend && (aw_first >= 0 || cycles >= lead);
        wvalid  = w_pend && (aw_first <= 0 || cycles >= lead);
    end
    // response phase, bready held low for bready_delay cycles
    bready     = (bready_delay == 0);
    cycles     = 0;
    b_seen     = 1'b0;
    b_done     = 1'b0;
    last_stall = 0;
    while (!b_done) begin
        #1;
        if (bvalid) begin
            b_seen = 1'b1;
            if (awready || wready) begin
                report_error("awready or wready high while the response waits");
            end
            if (bready) begin
                b_done = 1'b1;
                compare("bresp", 64'(RESP_OKAY), 64'(bresp));
            end else begin
                last_stall++;
            end
        end else if (b_seen) begin
            report_error("bvalid dropped before bready");
            b_done = 1'b1;
        end
        next_cycle();
        cycles++;
        if (cycles >= bready_delay) begin
            bready = 1'b1;
        end
    end
    bready = 1'b0;
endtask

// full write at a word index, both channels together
task automatic write_word(input word_idx_t word, input data_t data, input strb_t strb);
    axil_write({word, 2'b00}, data, strb, 0, 0);
endtask

task automatic check_reset_values();
    begin_test("reset_values");
    check_src();
    check_ids();
    compare("cell_wr", 64'd0, 64'(cell_wr));
    compare("bvalid", 64'd0, 64'(bvalid));
    compare("awready", 64'd1, 64'(awready));
    compare("wready", 64'd1, 64'(wready));
    end_test();
endtask

task automatic write_source_params();
    word_idx_t words [10] = '{WORD_CONTROL, WORD_CONTROL, WORD_IP_SRC, WORD_MAC_SRC_LO,
                              WORD_MAC_SRC_LO, WORD_MAC_SRC_HI, WORD_MAC_SRC_HI,
                              WORD_PORT_SRC, WORD_PORT_SRC, WORD_IP_SRC};
    strb_t strbs [10] = '{4'b1111, 4'b0101, 4'b1010, 4'b1111, 4'b0110,
                          4'b1111, 4'b1110, 4'b1111, 4'b0101, 4'b1001};
    data_t d;
    begin_test("source_writes");
    for (int i = 0; i < 10; i++) begin
        rand_word(d);
        write_word(words[i], d, strbs[i]);
        case (words[i])
            WORD_CONTROL:    exp_control = expect_merge(exp_control, d, strbs[i]);
            WORD_MAC_SRC_HI: exp_mac_src[47:32] = expect_half(exp_mac_src[47:32], d, strbs[i]);
            WORD_MAC_SRC_LO: exp_mac_src[31:0] = expect_merge(exp_mac_src[31:0], d, strbs[i]);
            WORD_IP_SRC:     exp_ip_src = expect_merge(exp_ip_src, d, strbs[i]);
            default:         exp_port_src = expect_half(exp_port_src, d, strbs[i]);
        endcase
        check_src();
    end
    end_test();
endtask

task automatic stage_destination();
    word_idx_t words [5] = '{WORD_CELL_ADDR, WORD_MAC_DEST_HI, WORD_MAC_DEST_LO,
                             WORD_IP_DEST, WORD_PORT_DEST};
    data_t d;
    int pulses_before;
    begin_test("dest_staging");
    for (int i = 0; i < 5; i++) begin
        rand_word(d);
        write_word(words[i], d, 4'b1111);
        case (words[i])
            WORD_CELL_ADDR:   exp_cell_addr = d;
            WORD_MAC_DEST_HI: exp_mac_dest[47:32] = d[15:0];
            WORD_MAC_DEST_LO: exp_mac_dest[31:0] = d;
            WORD_IP_DEST:     exp_ip_dest = d;
            default:          exp_port_dest = d[15:0];
        endcase
    end
    check_dest();
    // upper bits of the word carry junk, only bits 2 to 0 count
    pulses_before = pulse_count;
    write_word(WORD_CELL_WRITE, 32'hffff_ff05, 4'b0001);
    repeat (3) next_cycle();
    compare("cell_wr pulse count", 64'(pulses_before + 1), 64'(pulse_count));
    compare("cell_wr pulse value", 64'd5, 64'(pulse_value));
    compare("cell_addr at pulse", 64'(exp_cell_addr), 64'(pulse_cell_addr));
    compare("mac_dest at pulse", 64'(exp_mac_dest), 64'(pulse_mac));
    compare("ip_dest at pulse", 64'(exp_ip_dest), 64'(pulse_ip));
    compare("port_dest at pulse", 64'(exp_port_dest), 64'(pulse_port));
    compare("cell_wr after pulse", 64'd0, 64'(cell_wr));
    // lane 0 off means no table write
    pulses_before = pulse_count;
    write_word(WORD_CELL_WRITE, 32'h0000_0707, 4'b0010);
    repeat (3) next_cycle();
    compare("cell_wr pulse count", 64'(pulses_before), 64'(pulse_count));
    check_dest();
    end_test();
endtask

task automatic lock_id_fields();
    strb_t strbs [4] = '{4'b1111, 4'b0011, 4'b1100, 4'b1001};
    data_t d;
    begin_test("id_locking");
    rand_word(d);
    write_word(WORD_SERIAL, d, 4'b1111);
    check_ids();
    for (int i = 0; i < 4; i++) begin
        rand_word(d);
        write_word(word_idx_t'(WORD_WRAND + i), d, strbs[i]);
        exp_codes[i] = expect_merge(exp_codes[i], d, strbs[i]);
        check_ids();
    end
    // word 20 is outside the map
    rand_word(d);
    write_word(5'd20, d, 4'b1111);
    check_src();
    check_dest();
    check_ids();
    compare("cell_wr", 64'd0, 64'(cell_wr));
    end_test();
endtask

task automatic order_and_backpressure();
    int leads [3] = '{-2, 2, 0};
    data_t d;
    begin_test("order_backpressure");
    for (int i = 0; i < 3; i++) begin
        rand_word(d);
        axil_write({WORD_CONTROL, 2'b00}, d, 4'b1111, leads[i], 0);
        exp_control = d;
        check_src();
    end
    // response held back for 6 cycles after the last handshake
    rand_word(d);
    axil_write({WORD_IP_SRC, 2'b00}, d, 4'b1111, 1, 6);
    exp_ip_src = d;
    compare("cycles bvalid waited", 64'd5, 64'(last_stall));
    compare("awready after response", 64'd1, 64'(awready));
    compare("wready after response", 64'd1, 64'(wready));
    compare("bvalid after response", 64'd0, 64'(bvalid));
    check_src();
    end_test();
endtask

//--- bench/tb_umstr_cfg_regs.sv
`timescale 1ns/1ps

module tb_umstr_cfg_regs;
    import umstr_cfg_pkg::*;

    // the tests take about 400 cycles, five times that is the limit
    localparam int TIMEOUT_CYCLES = 2000;
    localparam logic [31:0] LFSR_SEED = 32'ha2d9;

    logic clk;
    logic reset_n;

    // axi-lite write side
    axil_addr_t awaddr;
    logic       awvalid;
    logic       awready;
    data_t      wdata;
    strb_t      wstrb;
    logic       wvalid;
    logic       wready;
    logic [1:0] bresp;
    logic       bvalid;
    logic       bready;

    // register outputs
    data_t    control;
    mac_t     mac_src;
    ip_t      ip_src;
    port_t    port_src;
    data_t    cell_addr;
    mac_t     mac_dest;
    ip_t      ip_dest;
    port_t    port_dest;
    cell_wr_t cell_wr;
    data_t    serial;
    data_t    wrand_code;
    data_t    wburst_code;
    data_t    rrand_code;
    data_t    rburst_code;

    // expected register contents
    data_t exp_control;
    mac_t  exp_mac_src;
    ip_t   exp_ip_src;
    port_t exp_port_src;
    data_t exp_cell_addr;
    mac_t  exp_mac_dest;
    ip_t   exp_ip_dest;
    port_t exp_port_dest;
    // wrand, wburst, rrand, rburst in map order
    data_t exp_codes [4];

    // bookkeeping
    int          errors;
    int          checks;
    int          tests_run;
    int          test_errors_at_start;
    string       test_name;
    logic [31:0] lfsr;
    int          cycle_count;
    int          last_stall;

    // what the cell-write monitor saw
    int       pulse_count;
    cell_wr_t pulse_value;
    data_t    pulse_cell_addr;
    mac_t     pulse_mac;
    ip_t      pulse_ip;
    port_t    pulse_port;

    umstr_cfg_regs UUT (
        .clk_i         (clk),
        .reset_n_i     (reset_n),
        .awaddr_i      (awaddr),
        .awvalid_i     (awvalid),
        .awready_o     (awready),
        .wdata_i       (wdata),
        .wstrb_i       (wstrb),
        .wvalid_i      (wvalid),
        .wready_o      (wready),
        .bresp_o       (bresp),
        .bvalid_o      (bvalid),
        .bready_i      (bready),
        .control_o     (control),
        .mac_src_o     (mac_src),
        .ip_src_o      (ip_src),
        .port_src_o    (port_src),
        .cell_addr_o   (cell_addr),
        .mac_dest_o    (mac_dest),
        .ip_dest_o     (ip_dest),
        .port_dest_o   (port_dest),
        .cell_wr_o     (cell_wr),
        .serial_o      (serial),
        .wrand_code_o  (wrand_code),
        .wburst_code_o (wburst_code),
        .rrand_code_o  (rrand_code),
        .rburst_code_o (rburst_code)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // run limit
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles, the tests did not finish", TIMEOUT_CYCLES);
        $display("** FAIL **");
        $finish;
    end

    // sampled mid cycle, away from both edges of activity
    initial pulse_count = 0;
    always @(negedge clk) begin
        if (cell_wr != '0) begin
            pulse_count++;
            pulse_value     = cell_wr;
            pulse_cell_addr = cell_addr;
            pulse_mac       = mac_dest;
            pulse_ip        = ip_dest;
            pulse_port      = port_dest;
        end
    end

    // inputs move half a ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    // fibonacci lfsr, taps at bits 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    // one lfsr step per data bit
    task automatic rand_word(output data_t word);
        for (int b = 0; b < 32; b++) begin
            lfsr = lfsr_step(lfsr);
            word = {word[30:0], lfsr[0]};
        end
    endtask

    // strobed bytes come from the new word
    function automatic data_t expect_merge(input data_t old_word, input data_t new_word,
                                           input strb_t strb);
        data_t mask;
        mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
        return (old_word & ~mask) | (new_word & mask);
    endfunction

    // 16 bit fields only see lanes 0 and 1
    function automatic logic [15:0] expect_half(input logic [15:0] old_half,
                                                input data_t new_word, input strb_t strb);
        logic [15:0] mask;
        mask = {{8{strb[1]}}, {8{strb[0]}}};
        return (old_half & ~mask) | (new_word[15:0] & mask);
    endfunction

    task automatic compare(input string what, input logic [63:0] expected,
                           input logic [63:0] actual);
        checks++;
        if (actual !== expected) begin
            $display("FAIL %s %s expected %0h actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("error in %s, %s", test_name, what);
    endtask

    task automatic begin_test(input string name);
        test_name = name;
        test_errors_at_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_errors_at_start) begin
            $display("test %s ok", test_name);
        end else begin
            $display("test %s failed with %0d errors", test_name, errors - test_errors_at_start);
        end
    endtask

    task automatic check_src();
        compare("control", 64'(exp_control), 64'(control));
        compare("mac_src", 64'(exp_mac_src), 64'(mac_src));
        compare("ip_src", 64'(exp_ip_src), 64'(ip_src));
        compare("port_src", 64'(exp_port_src), 64'(port_src));
    endtask

    task automatic check_dest();
        compare("cell_addr", 64'(exp_cell_addr), 64'(cell_addr));
        compare("mac_dest", 64'(exp_mac_dest), 64'(mac_dest));
        compare("ip_dest", 64'(exp_ip_dest), 64'(ip_dest));
        compare("port_dest", 64'(exp_port_dest), 64'(port_dest));
    endtask

    // serial is locked with the default parameters
    task automatic check_ids();
        compare("serial", 64'(SERIAL_DEFAULT), 64'(serial));
        compare("wrand_code", 64'(exp_codes[0]), 64'(wrand_code));
        compare("wburst_code", 64'(exp_codes[1]), 64'(wburst_code));
        compare("rrand_code", 64'(exp_codes[2]), 64'(rrand_code));
        compare("rburst_code", 64'(exp_codes[3]), 64'(rburst_code));
    endtask

    `include "tb_axil_tasks.svh"

    initial begin
        reset_n = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wstrb   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        lfsr    = LFSR_SEED;
        errors    = 0;
        checks    = 0;
        tests_run = 0;
        last_stall = 0;
        test_name = "none";
        // reset image of the writable registers
        exp_control  = '0;
        exp_mac_src  = MAC_SRC_DEFAULT;
        exp_ip_src   = IP_SRC_DEFAULT;
        exp_port_src = PORT_SRC_DEFAULT;
        exp_codes[0] = WRAND_DEFAULT;
        exp_codes[1] = WBURST_DEFAULT;
        exp_codes[2] = RRAND_DEFAULT;
        exp_codes[3] = RBURST_DEFAULT;
        repeat (5) @(posedge clk);
        #0.5;
        reset_n = 1'b1;
        check_reset_values();
        write_source_params();
        stage_destination();
        lock_id_fields();
        order_and_backpressure();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+include
hw/umstr_cfg_pkg.sv
hw/axil_write_slave.sv
hw/src_param_regs.sv
hw/dest_cell_stage.sv
hw/id_code_regs.sv
hw/umstr_cfg_regs.sv
bench/tb_umstr_cfg_regs.sv

//--- run.sh
#!/bin/sh
# build the testbench with verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_umstr_cfg_regs -f verilog.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qxF '** PASS **'
